// File: tb.f
+incdir+test
source/alu_pkg.sv
source/alu_cmd_if.sv
source/operand_gate.sv
source/cmd_fifo.sv
source/alu_exec.sv
source/alu_top.sv
test/tb_alu_top.sv

// File: test/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// what one accepted command should give back, queued in command order
typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              carry;
    logic              bad;
} expect_t;

// the model's own carry flag, clear after reset like the DUT's
logic model_carry = 1'b0;

// gating first, then the opcode table worked out on plain integers
// a sum that passes the byte top sets the carry
// a difference below zero sets it as a borrow
function automatic expect_t model_step(input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y,
                                       input logic [OP_W-1:0] op_in, input logic zero_x,
                                       input logic pass_x);
    expect_t         e;
    logic [OP_W-1:0] op;
    int              a;
    int              b;
    int              r;
    a     = zero_x ? 0 : int'(x);
    b     = int'(y);
    op    = pass_x ? OP_A : op_in;
    r     = 0;
    e.bad = 1'b0;
    case (op)
        OP_A:         r = a;
        OP_B:         r = b;
        OP_ZERO:      r = 0;
        OP_MINUS_A:   r = -a;
        OP_MINUS_B:   r = -b;
        OP_A_PLUS_1:  r = a + 1;
        OP_B_PLUS_1:  r = b + 1;
        OP_A_MINUS_1: r = a - 1;
        OP_B_MINUS_1: r = b - 1;
        OP_A_PLUS_B: begin
            r           = a + b + int'(model_carry);
            model_carry = (r >= (1 << DATA_W));
        end
        OP_A_MINUS_B: begin
            r           = a - b - int'(model_carry);
            model_carry = (r < 0);
        end
        OP_B_MINUS_A: begin
            r           = b - a - int'(model_carry);
            model_carry = (r < 0);
        end
        OP_A_AND_B:   r = a & b;
        OP_A_OR_B:    r = a | b;
        OP_A_XOR_B:   r = a ^ b;
        OP_NOT_A:     r = ~a;
        OP_NOT_B:     r = ~b;
        // anything else is a bad code, zero out and the flag stays
        default:      e.bad = 1'b1;
    endcase
    // the low byte of r is right for negative values too
    e.data  = r[DATA_W-1:0];
    e.carry = model_carry;
    return e;
endfunction

`endif

// File: test/tb_alu_top.sv
module tb_alu_top;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    `include "alu_ref_model.svh"

    localparam logic [31:0] LFSR_SEED      = 32'h2b93f181;
    localparam int          ACCEPT_TIMEOUT = 200;
    localparam int          DRAIN_TIMEOUT  = 400;

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    logic [DATA_W-1:0] cmd_x;
    logic [DATA_W-1:0] cmd_y;
    logic [OP_W-1:0]   cmd_op;
    logic              cmd_zero_x;
    logic              cmd_pass_x;
    logic              cmd_ready;
    logic              res_valid;
    logic [DATA_W-1:0] res_data;
    logic              res_carry;
    logic              res_bad_op;
    logic              res_ready;

    // expected results of accepted commands with the oldest at the front
    expect_t expect_q [$];

    // random source of the command side
    // res_ready has its own further down
    logic [31:0] cmd_lfsr = LFSR_SEED;
    // 0 keeps res_ready high, 1 holds it low, 2 gives random runs of both
    int          ready_mode;
    logic [31:0] bits;
    int          i;
    int          code;

    int value_errs   = 0;
    int order_errs   = 0;
    int seq_errs     = 0;
    int timeout_errs = 0;
    int cmd_count    = 0;
    int res_count    = 0;

    // output snapshot while a result waits on res_ready
    logic              held = 1'b0;
    logic [DATA_W+1:0] held_out;

    alu_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_x      (cmd_x),
        .cmd_y      (cmd_y),
        .cmd_op     (cmd_op),
        .cmd_zero_x (cmd_zero_x),
        .cmd_pass_x (cmd_pass_x),
        .cmd_ready  (cmd_ready),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_carry  (res_carry),
        .res_bad_op (res_bad_op),
        .res_ready  (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1 that steps once for each bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            r     = {r[30:0], fb};
        end
        return r;
    endfunction

    // puts a command on the input and is called 1 ns after an edge
    task automatic drive_cmd(input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y,
                             input logic [OP_W-1:0] op, input logic zero_x, input logic pass_x);
        cmd_x      = x;
        cmd_y      = y;
        cmd_op     = op;
        cmd_zero_x = zero_x;
        cmd_pass_x = pass_x;
        cmd_valid  = 1'b1;
    endtask

    // holds the command until an edge sees cmd_ready, then drops valid 1 ns later
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (cmd_ready !== 1'b1 && cycles < ACCEPT_TIMEOUT) begin
            cycles++;
            @(posedge clk);
        end
        if (cmd_ready !== 1'b1) begin
            timeout_errs++;
            $display("timeout: command not accepted within %0d cycles", ACCEPT_TIMEOUT);
        end
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic send_cmd(input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y,
                            input logic [OP_W-1:0] op, input logic zero_x, input logic pass_x);
        drive_cmd(x, y, op, zero_x, pass_x);
        wait_accept();
    endtask

    // random operands for a given code and pair of controls
    task automatic send_rand(input logic [OP_W-1:0] op, input logic zero_x, input logic pass_x);
        logic [31:0] xb;
        logic [31:0] yb;
        xb = lfsr_take(cmd_lfsr, DATA_W);
        yb = lfsr_take(cmd_lfsr, DATA_W);
        send_cmd(xb[DATA_W-1:0], yb[DATA_W-1:0], op, zero_x, pass_x);
    endtask

    // polls on the falling edge until every expected result has come back
    task automatic drain();
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (expect_q.size() != 0) begin
            timeout_errs++;
            $display("timeout: %0d results still missing after %0d cycles", expect_q.size(),
                     DRAIN_TIMEOUT);
        end
    endtask

    task automatic check_result();
        expect_t e;
        if (expect_q.size() == 0) begin
            order_errs++;
            $display("a result came out with no accepted command waiting for it");
        end else begin
            e = expect_q.pop_front();
            assert (res_data === e.data) else begin
                value_errs++;
                $display("[FAIL] res_data expected 0x%02h got 0x%02h", e.data, res_data);
            end
            assert (res_carry === e.carry) else begin
                value_errs++;
                $display("[FAIL] res_carry expected 0x%0h got 0x%0h", e.carry, res_carry);
            end
            assert (res_bad_op === e.bad) else begin
                value_errs++;
                $display("[FAIL] res_bad_op expected 0x%0h got 0x%0h", e.bad, res_bad_op);
            end
        end
    endtask

    // the res_ready mode is read on the edge and applied 1 ns later
    initial begin : ready_drive
        logic [31:0] rdy_lfsr;
        logic [31:0] rb;
        int          mode;
        int          run_left;
        logic        level;
        rdy_lfsr  = LFSR_SEED;
        run_left  = 0;
        level     = 1'b1;
        res_ready = 1'b1;
        forever begin
            @(posedge clk);
            mode = ready_mode;
            #1;
            if (mode == 2) begin
                // low runs of up to 16 cycles are long enough to fill the FIFO
                if (run_left == 0) begin
                    rb       = lfsr_take(rdy_lfsr, 5);
                    level    = rb[4];
                    run_left = level ? int'(rb[1:0]) + 1 : int'(rb[3:0]) + 1;
                end
                run_left--;
                res_ready = level;
            end else begin
                run_left  = 0;
                res_ready = (mode == 0);
            end
        end
    end

    // the scoreboard samples both handshakes on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (cmd_valid && cmd_ready) begin
                expect_q.push_back(model_step(cmd_x, cmd_y, cmd_op, cmd_zero_x, cmd_pass_x));
                cmd_count++;
            end
            // a result that waits on res_ready must neither move nor vanish
            if (held) begin
                assert (res_valid === 1'b1) else begin
                    order_errs++;
                    $display("[FAIL] res_valid expected 0x1 got 0x%0h while res_ready was low",
                             res_valid);
                end
                assert ({res_data, res_carry, res_bad_op} === held_out) else begin
                    order_errs++;
                    $display("[FAIL] {res_data,res_carry,res_bad_op} held 0x%03h got 0x%03h",
                             held_out, {res_data, res_carry, res_bad_op});
                end
            end
            if (res_valid === 1'b1 && res_ready) begin
                res_count++;
                check_result();
            end
            held     = (res_valid === 1'b1) && !res_ready;
            held_out = {res_data, res_carry, res_bad_op};
        end else begin
            held = 1'b0;
        end
    end

    initial begin
        rst_n      = 1'b0;
        ready_mode = 0;
        cmd_valid  = 1'b0;
        cmd_x      = '0;
        cmd_y      = '0;
        cmd_op     = '0;
        cmd_zero_x = 1'b0;
        cmd_pass_x = 1'b0;
        // outputs are known from the second edge of reset on
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0) begin
                assert (res_valid === 1'b0) else begin
                    seq_errs++;
                    $display("[FAIL] res_valid expected 0x0 got 0x%0h during reset", res_valid);
                end
                assert (cmd_ready === 1'b0) else begin
                    seq_errs++;
                    $display("[FAIL] cmd_ready expected 0x0 got 0x%0h during reset", cmd_ready);
                end
            end
        end
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        assert (res_valid === 1'b0) else begin
            seq_errs++;
            $display("[FAIL] res_valid expected 0x0 got 0x%0h after reset", res_valid);
        end
        @(posedge clk);
        assert (cmd_ready === 1'b1) else begin
            seq_errs++;
            $display("[FAIL] cmd_ready expected 0x1 got 0x%0h after reset", cmd_ready);
        end
        #1;
        // with a clear carry in, 0xff + 0x01 gives 0x00 and sets the carry
        send_cmd(8'hff, 8'h01, OP_A_PLUS_B, 1'b0, 1'b0);

        // every supported code with random operands
        for (code = 0; code < 32; code++) begin
            if (code < 12 || (code > 24 && code < 30)) begin
                for (i = 0; i < 4; i++) begin
                    send_rand(code[OP_W-1:0], 1'b0, 1'b0);
                end
            end
        end
        // wraparound at the byte edges
        send_cmd(8'h80, 8'h00, OP_MINUS_A, 1'b0, 1'b0);
        send_cmd(8'h00, 8'h80, OP_MINUS_B, 1'b0, 1'b0);
        send_cmd(8'hff, 8'h00, OP_A_PLUS_1, 1'b0, 1'b0);
        send_cmd(8'h00, 8'hff, OP_B_PLUS_1, 1'b0, 1'b0);
        send_cmd(8'h00, 8'h00, OP_A_MINUS_1, 1'b0, 1'b0);
        send_cmd(8'h00, 8'h00, OP_B_MINUS_1, 1'b0, 1'b0);

        // chained adds and subtracts with other ops between them that must keep the flag
        for (i = 0; i < 40; i++) begin
            bits = lfsr_take(cmd_lfsr, 3);
            case (bits[2:0])
                3'd0, 3'd1, 3'd2: send_rand(OP_A_PLUS_B, 1'b0, 1'b0);
                3'd3, 3'd4:       send_rand(OP_A_MINUS_B, 1'b0, 1'b0);
                3'd5:             send_rand(OP_B_MINUS_A, 1'b0, 1'b0);
                3'd6:             send_rand(OP_NOT_B, 1'b0, 1'b0);
                default:          send_rand(OP_B_PLUS_1, 1'b0, 1'b0);
            endcase
        end

        // zero_x alone, pass_x alone, then both, on random codes
        for (i = 0; i < 36; i++) begin
            bits = lfsr_take(cmd_lfsr, OP_W);
            send_rand(bits[OP_W-1:0], (i % 3) != 1, (i % 3) != 0);
        end

        // unknown codes once with the carry set and once with it clear
        for (i = 0; i < 2; i++) begin
            if (i == 0) begin
                send_cmd(8'hff, 8'hff, OP_A_PLUS_B, 1'b0, 1'b0);
            end else begin
                send_cmd(8'h00, 8'h00, OP_A_PLUS_B, 1'b0, 1'b0);
            end
            for (code = 12; code < 32; code++) begin
                if (code < 25 || code > 29) begin
                    send_rand(code[OP_W-1:0], 1'b0, 1'b0);
                end
            end
        end

        // with the result held back the FIFO and then the gate register fill up
        drain();
        ready_mode = 1;
        repeat (2) @(posedge clk);
        #1;
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_rand(OP_A_PLUS_B, 1'b0, 1'b0);
        end
        drive_cmd(8'h5a, 8'h3c, OP_A_XOR_B, 1'b0, 1'b0);
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            assert (cmd_ready === 1'b0) else begin
                seq_errs++;
                $display("[FAIL] cmd_ready expected 0x0 got 0x%0h with the FIFO full",
                         cmd_ready);
            end
        end
        #1;
        ready_mode = 0;
        wait_accept();

        // random stalls of short and long runs against a busy command stream
        ready_mode = 2;
        for (i = 0; i < 160; i++) begin
            bits = lfsr_take(cmd_lfsr, OP_W + 6);
            send_rand(bits[OP_W-1:0], bits[OP_W+2:OP_W] == 3'd0, bits[OP_W+5:OP_W+3] == 3'd0);
        end
        ready_mode = 0;
        drain();
        // no stray result may follow once every expected one is back
        repeat (FIFO_DEPTH + 4) @(posedge clk);
        assert (cmd_count == res_count) else begin
            seq_errs++;
            $display("%0d commands were accepted but %0d results came out", cmd_count, res_count);
        end

        $display("errors: value %0d, order %0d, sequence %0d, timeout %0d",
                 value_errs, order_errs, seq_errs, timeout_errs,
                 " (commands %0d, results %0d)", cmd_count, res_count);
        if (value_errs + order_errs + seq_errs + timeout_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: source/alu_top.sv
// top of the arithmetic unit
// commands go through the gating stage, the buffer and then the ALU
// with no stall a result shows three cycles after the command is taken
module alu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // command input
    input  logic                       cmd_valid,
    input  logic [alu_pkg::DATA_W-1:0] cmd_x,
    input  logic [alu_pkg::DATA_W-1:0] cmd_y,
    input  logic [alu_pkg::OP_W-1:0]   cmd_op,
    input  logic                       cmd_zero_x,
    input  logic                       cmd_pass_x,
    output logic                       cmd_ready,
    // result output
    output logic                       res_valid,
    output logic [alu_pkg::DATA_W-1:0] res_data,
    output logic                       res_carry,
    output logic                       res_bad_op,
    input  logic                       res_ready
);

    // gated commands into the buffer
    alu_cmd_if gate_to_fifo ();

    // buffered commands into the ALU
    alu_cmd_if fifo_to_exec ();

    // zero-x and pass-x gating, one register deep
    operand_gate gate_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_x      (cmd_x),
        .cmd_y      (cmd_y),
        .cmd_op     (cmd_op),
        .cmd_zero_x (cmd_zero_x),
        .cmd_pass_x (cmd_pass_x),
        .cmd_ready  (cmd_ready),
        .gated      (gate_to_fifo.source)
    );

    // absorbs stalls on the result side
    cmd_fifo fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (gate_to_fifo.sink),
        .rd    (fifo_to_exec.source)
    );

    // opcode table, carry flag and result register
    alu_exec exec_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (fifo_to_exec.sink),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_carry  (res_carry),
        .res_bad_op (res_bad_op),
        .res_ready  (res_ready)
    );

endmodule

// File: source/alu_exec.sv
// the ALU stage proper
// it runs the opcode table on a 9-bit datapath so bit 8 comes out as the
// carry or the borrow, and it keeps the carry flag between commands
// so a chain of adds or subtracts works over more than one byte
module alu_exec (
    input  logic                       clk,
    input  logic                       rst_n,
    alu_cmd_if.sink                    cmd,
    output logic                       res_valid,
    output logic [alu_pkg::DATA_W-1:0] res_data,
    output logic                       res_carry,
    output logic                       res_bad_op,
    input  logic                       res_ready
);
    import alu_pkg::*;

    // incoming command and its decoded opcode
    alu_cmd_t        c;
    alu_op_e         op_e;

    // operands and stored carry widened to the 9-bit datapath
    logic [DATA_W:0] a9;
    logic [DATA_W:0] b9;
    logic [DATA_W:0] c9;

    // combinational result of the table
    logic [DATA_W:0] calc;
    logic            carry_nxt;
    logic            bad_nxt;

    // result register, carry_q is also the carry flag itself
    logic [DATA_W-1:0] data_q;
    logic              valid_q;
    logic              carry_q;
    logic              bad_q;

    // handshake on the command side
    logic            take;

    assign c    = cmd.cmd;
    assign op_e = alu_op_e'(c.op);

    assign a9 = {1'b0, c.x};
    assign b9 = {1'b0, c.y};
    assign c9 = {{DATA_W{1'b0}}, carry_q};

    // a new command can enter when the result register is free or its
    // content leaves in the same cycle
    assign cmd.ready = !valid_q || res_ready;
    assign take      = cmd.valid && cmd.ready;

    always_comb begin
        calc      = '0;
        carry_nxt = carry_q;
        bad_nxt   = 1'b0;
        case (op_e)
            OP_A:         calc = a9;
            OP_B:         calc = b9;
            OP_ZERO:      calc = '0;
            // negation and the +1/-1 ops wrap in eight bits
            // and do not touch the carry
            OP_MINUS_A:   calc = '0 - a9;
            OP_MINUS_B:   calc = '0 - b9;
            OP_A_PLUS_1:  calc = a9 + 1'b1;
            OP_B_PLUS_1:  calc = b9 + 1'b1;
            OP_A_MINUS_1: calc = a9 - 1'b1;
            OP_B_MINUS_1: calc = b9 - 1'b1;
            // the add takes its carry in from the flag and bit 8 is the
            // carry out
            OP_A_PLUS_B: begin
                calc      = a9 + b9 + c9;
                carry_nxt = calc[DATA_W];
            end
            // for the subtracts the flag acts as a borrow in, a negative
            // difference sets bit 8 and that is the borrow out
            OP_A_MINUS_B: begin
                calc      = a9 - b9 - c9;
                carry_nxt = calc[DATA_W];
            end
            OP_B_MINUS_A: begin
                calc      = b9 - a9 - c9;
                carry_nxt = calc[DATA_W];
            end
            OP_A_AND_B:   calc = a9 & b9;
            OP_A_OR_B:    calc = a9 | b9;
            OP_A_XOR_B:   calc = a9 ^ b9;
            OP_NOT_A:     calc = {1'b0, ~c.x};
            OP_NOT_B:     calc = {1'b0, ~c.y};
            // unlisted codes give zero, keep the carry and are flagged
            default:      bad_nxt = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            carry_q <= 1'b0;
        end else begin
            if (take) begin
                valid_q <= 1'b1;
            end else if (res_ready) begin
                valid_q <= 1'b0;
            end
            // the flag moves with the result it belongs to, which also
            // means it holds while a result waits on res_ready
            if (take) begin
                carry_q <= carry_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= calc[DATA_W-1:0];
            bad_q  <= bad_nxt;
        end
    end

    assign res_valid  = valid_q;
    assign res_data   = data_q;
    assign res_carry  = carry_q;
    assign res_bad_op = bad_q;

endmodule

// File: source/cmd_fifo.sv
// buffer of gated commands between the gating stage and the ALU
// a circular store with read and write pointers one bit wider than the
// address and the extra bit tells a full buffer from an empty one
module cmd_fifo (
    input  logic      clk,
    input  logic      rst_n,
    alu_cmd_if.sink   wr,
    alu_cmd_if.source rd
);
    import alu_pkg::*;

    // storage of the buffered commands
    alu_cmd_t         mem [FIFO_DEPTH];

    // read and write pointers whose top bit flips on every wrap
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;

    // status from the pointer compare
    logic             full;
    logic             empty;

    // transfers on each side in this cycle
    logic             do_wr;
    logic             do_rd;

    // equal pointers mean nothing is stored
    assign empty = (wr_ptr == rd_ptr);

    // same address but a different wrap bit means the writer is a whole
    // lap ahead of the reader
    assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    // a full buffer refuses writes even if a read is going on
    // that keeps the ready path free of the downstream ready
    assign wr.ready = !full;
    assign rd.valid = !empty;

    // the head entry is shown straight from storage
    // a written word shows up here on the cycle after the write
    assign rd.cmd = mem[rd_ptr[FIFO_AW-1:0]];

    assign do_wr = wr.valid && !full;
    assign do_rd = rd.ready && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // a read and a write can share a cycle and never hit the same entry
    // because a full buffer blocks the write
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr.cmd;
        end
    end

endmodule

// File: source/operand_gate.sv
// front stage of the arithmetic unit
// on the board the x operand and the opcode went through bus transceivers
// with pull-downs behind them, so turning a transceiver off gave zero
// here the same effect is made with muxes and the result is registered
module operand_gate (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  logic [alu_pkg::DATA_W-1:0] cmd_x,
    input  logic [alu_pkg::DATA_W-1:0] cmd_y,
    input  logic [alu_pkg::OP_W-1:0]   cmd_op,
    input  logic                       cmd_zero_x,
    input  logic                       cmd_pass_x,
    output logic                       cmd_ready,
    alu_cmd_if.source                  gated
);
    import alu_pkg::*;

    // gated command before it is registered
    alu_cmd_t          gated_cmd;
    logic [DATA_W-1:0] x_g;
    logic [OP_W-1:0]   op_g;

    // one-entry output register
    alu_cmd_t          cmd_q;
    logic              valid_q;

    // goes high on the first edge out of reset and stays there
    // it keeps the input closed while reset is applied
    logic              run_q;

    // handshake on the command input
    logic              accept;

    // zero_x stands for the x transceiver being disabled
    // the pull-downs then put zero on the x bus
    assign x_g = cmd_zero_x ? '0 : cmd_x;

    // pass_x disables the opcode transceiver, so the op bus reads zero
    // and zero is the pass-A code
    assign op_g = cmd_pass_x ? OP_A : cmd_op;

    assign gated_cmd.x  = x_g;
    assign gated_cmd.y  = cmd_y;
    assign gated_cmd.op = op_g;

    // the register can take a new word when it is empty or is being
    // emptied in this same cycle, so a steady stream runs at full rate
    assign cmd_ready = run_q && (!valid_q || gated.ready);
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            // a new word keeps valid up, otherwise it drops once taken
            if (accept) begin
                valid_q <= 1'b1;
            end else if (gated.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // payload only moves on an accepted command
    // while the downstream stalls it stays as it is
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= gated_cmd;
        end
    end

    assign gated.valid = valid_q;
    assign gated.cmd   = cmd_q;

endmodule

// File: source/alu_cmd_if.sv
// a gated command stream between two stages of the arithmetic unit
// a word moves on a rising edge where valid and ready are both high
// once valid goes up, valid and cmd hold until that edge
interface alu_cmd_if;
    import alu_pkg::*;

    // set by the producer while cmd holds a word to pass on
    logic     valid;

    // set by the consumer when it can take the word this cycle
    logic     ready;

    // gated operands and opcode
    alu_cmd_t cmd;

    // the side that offers commands
    modport source (
        output valid,
        output cmd,
        input  ready
    );

    // the side that takes commands
    modport sink (
        input  valid,
        input  cmd,
        output ready
    );

endinterface

// File: source/alu_pkg.sv
package alu_pkg;

    // operand and result width of the datapath
    localparam int DATA_W = 8;

    // the opcode field is five bits wide, as on the original control word
    localparam int OP_W = 5;

    // number of gated commands the buffer can hold
    // this has to stay a power of two so the pointers wrap cleanly
    localparam int FIFO_DEPTH = 4;

    // address width of the buffer, the pointers carry one extra wrap bit
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // opcode table of the arithmetic unit
    // codes 0 to 11 and 25, 26 match the board encodings, 27 to 29 are new
    // anything not listed here is treated as a bad opcode by the ALU
    typedef enum logic [OP_W-1:0] {
        // plain transfers
        OP_A          = 5'd0,
        OP_B          = 5'd1,
        OP_ZERO       = 5'd2,
        // two's complement negation
        OP_MINUS_A    = 5'd3,
        OP_MINUS_B    = 5'd4,
        // increment and decrement, these wrap at the byte boundary
        OP_A_PLUS_1   = 5'd5,
        OP_B_PLUS_1   = 5'd6,
        OP_A_MINUS_1  = 5'd7,
        OP_B_MINUS_1  = 5'd8,
        // the only ops that read and write the carry flag
        OP_A_PLUS_B   = 5'd9,
        OP_A_MINUS_B  = 5'd10,
        OP_B_MINUS_A  = 5'd11,
        // bitwise logic
        OP_A_AND_B    = 5'd25,
        OP_A_OR_B     = 5'd26,
        OP_A_XOR_B    = 5'd27,
        OP_NOT_A      = 5'd28,
        OP_NOT_B      = 5'd29
    } alu_op_e;

    // one command after the gating stage
    // op is kept as raw bits so an unlisted code reaches the ALU untouched
    // and can be flagged there instead of being lost on the way
    typedef struct packed {
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        logic [OP_W-1:0]   op;
    } alu_cmd_t;

endpackage
